// File: dv/config_checker.sv
/*
 * Loader and parameter bank assertions, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

`include "config_cfg.svh"

module config_checker (
	input logic                    ADC_CLK,
	input logic                    rst_n,
	input logic                    wr_en,
	input config_pkg::param_idx_t  wr_idx,
	input logic                    clear,
	input config_pkg::gpio_word_t  wr_data,
	input logic                    cfg_done,
	input config_pkg::led_word_t   led_out,
	input config_pkg::param_bank_t params
);

	config_pkg::gpio_word_t [`NUM_PARAMS-1:0] words;
	int fail_count = 0;

	assign words = params;

	wr_clear_excl: assert property (@(posedge ADC_CLK) disable iff (!rst_n) !(wr_en && clear))
	else
	begin
		$error("wr_en and clear high together");
		fail_count++;
	end

	done_led: assert property (@(posedge ADC_CLK) disable iff (!rst_n) cfg_done |-> led_out == 8'd17)
	else
	begin
		$error("cfg_done high with led_out %0d", led_out);
		fail_count++;
	end

	// Written word shows up on params the next cycle
	wr_lands: assert property (@(posedge ADC_CLK) disable iff (!rst_n)
		wr_en |=> words[$past(wr_idx)] == $past(wr_data))
	else
	begin
		$error("written word missing from params");
		fail_count++;
	end

endmodule

bind config_top config_checker u_checker (
	.ADC_CLK  (ADC_CLK),
	.rst_n    (rst_n),
	.wr_en    (wr_en),
	.wr_idx   (wr_idx),
	.clear    (clear),
	.wr_data  (GPIO_1),
	.cfg_done (cfg_done),
	.led_out  (led_out),
	.params   (params)
);

`default_nettype wire

// File: dv/config_monitor.sv
/*
 * Output monitor, compares the DUT ports with the expected values and counts errors
 */
`timescale 1ns/1ps
`default_nettype none

module config_monitor (
	input  logic                    ADC_CLK,
	input  config_pkg::led_word_t   led_out,
	input  config_pkg::param_bank_t params,
	input  logic                    cfg_done,
	input  config_pkg::dac_code_t   dac_out,
	input  logic                    chk_cfg,
	input  config_pkg::led_word_t   exp_led,
	input  config_pkg::param_bank_t exp_params,
	input  logic                    chk_dac,
	input  config_pkg::dac_code_t   exp_dac,
	output int                      error_count,
	output int                      check_count
);

	config_pkg::gpio_word_t [15:0] got_words;
	config_pkg::gpio_word_t [15:0] exp_words;
	int errs = 0;
	int chks = 0;

	assign got_words   = params;
	assign exp_words   = exp_params;
	assign error_count = errs;
	assign check_count = chks;

	always @(posedge ADC_CLK)
	begin
		if (chk_cfg)
		begin
			chks++;
			if (led_out !== exp_led)
			begin
				errs++;
				$display("FAILED at %0t: led_out %0d, expected %0d", $time, led_out, exp_led);
			end
			if (cfg_done !== (exp_led == 8'd17)) // Done exactly in state 17
			begin
				errs++;
				$display("FAILED at %0t: cfg_done %0b in state %0d", $time, cfg_done, exp_led);
			end
			for (int i = 0; i < 16; i++)
			begin
				if (got_words[i] !== exp_words[i])
				begin
					errs++;
					$display("FAILED at %0t: word %0d is %h, expected %h", $time, i,
						got_words[i], exp_words[i]);
				end
			end
		end
		if (chk_dac)
		begin
			chks++;
			if (dac_out !== exp_dac)
			begin
				errs++;
				$display("FAILED at %0t: dac_out %0d, expected %0d", $time, dac_out, exp_dac);
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/config_tb.sv
/*
 * Testbench for the configuration front end
 * Loads parameter sessions over GPIO and streams ADC samples through the scaler
 */
`timescale 1ns/1ps
`default_nettype none

`include "config_cfg.svh"

module config_tb;

	localparam int TICK_CYCLES = 10;
	localparam int NUM_SAMPLES = 40;
	// Four sessions' worth of ticks, two sample runs, then margin
	localparam int TIMEOUT_CYCLES = 4 * 17 * TICK_CYCLES + 2 * (NUM_SAMPLES + 2) + 200;

	logic ADC_CLK = 1'b0;
	logic rst_n;
	config_pkg::gpio_word_t GPIO_0;
	config_pkg::gpio_word_t GPIO_1;
	config_pkg::adc_sample_t adc_in;
	config_pkg::led_word_t led_out;
	config_pkg::param_bank_t params;
	logic cfg_done;
	config_pkg::dac_code_t dac_out;
	config_pkg::gpio_word_t [15:0] exp_words; // Model of the bank
	config_pkg::led_word_t exp_led;
	config_pkg::dac_code_t exp_dac;
	logic chk_cfg;
	logic chk_dac;
	int mon_errors;
	int mon_checks;
	int errors;
	int cycle_count;
	int k;

	config_top UUT (.*);

	config_monitor u_monitor (
		.ADC_CLK (ADC_CLK), .led_out (led_out), .params (params), .cfg_done (cfg_done),
		.dac_out (dac_out), .chk_cfg (chk_cfg), .exp_led (exp_led), .exp_params (exp_words),
		.chk_dac (chk_dac), .exp_dac (exp_dac), .error_count (mon_errors),
		.check_count (mon_checks)
	);

	initial
	begin
		forever #5 ADC_CLK = ~ADC_CLK;
	end

	function automatic config_pkg::dac_code_t scale_ref(input int sample, input int gain,
		input int offset, input bit inv);
		int r;
		r = ((sample * gain) >>> `SCALE_SHIFT) + offset;
		if (inv)
			r = -r;
		if (r > 8191)
			r = 8191;
		else if (r < -8192)
			r = -8192;
		return config_pkg::dac_code_t'(r);
	endfunction

	task automatic next_cycle(input int n = 1);
		repeat (n) @(posedge ADC_CLK);
		#1;
	endtask

	// One state check, then optional cycles with dac_out expected at zero
	task automatic check_state(input int dac_cycles);
		chk_cfg = 1'b1;
		next_cycle();
		chk_cfg = 1'b0;
		exp_dac = '0;
		repeat (dac_cycles)
		begin
			adc_in  = config_pkg::adc_sample_t'($urandom);
			chk_dac = 1'b1;
			next_cycle();
		end
		chk_dac = 1'b0;
	endtask

	task automatic set_session(input bit en);
		GPIO_0[31] = en;
		if (!en)
		begin
			exp_words = '0;
			exp_led   = '0;
		end
		next_cycle(6);
	endtask

	// GPIO_1 held 2 cycles before to 8 cycles after the tick edge
	task automatic send_tick(input config_pkg::gpio_word_t word);
		GPIO_1 = word;
		next_cycle(2);
		GPIO_0[30] = 1'b1;
		next_cycle(5);
		GPIO_0[30] = 1'b0;
		if (exp_led < 16)
		begin
			exp_words[exp_led[3:0]] = word;
			exp_led++;
		end
		else
			exp_led = 8'd17;
		check_state(0);
		next_cycle(2);
	endtask

	task automatic load_session(input int num_ticks, input logic [15:0] gain,
		input logic [13:0] offset, input bit inv);
		config_pkg::gpio_word_t w;
		set_session(1'b1);
		for (int i = 0; i < num_ticks; i++)
		begin
			w = $urandom;
			if (i == 0)
				w[15:0] = gain;
			else if (i == 1)
				w[13:0] = offset; // Upper bits stay random
			else if (i == 2)
				w[0] = inv;
			send_tick(w);
		end
	endtask

	task automatic run_samples(input int n);
		config_pkg::adc_sample_t hist[$];
		for (int i = 0; i < n + 2; i++)
		begin
			if (i < n)
			begin
				adc_in = config_pkg::adc_sample_t'($urandom);
				hist.push_back(adc_in);
			end
			if (i >= 2)
			begin
				exp_dac = scale_ref(hist.pop_front(), $signed(exp_words[0][15:0]),
					$signed(exp_words[1][13:0]), exp_words[2][0]);
				chk_dac = 1'b1;
			end
			next_cycle();
		end
		chk_dac = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h226b_96ef));
		rst_n     = 1'b0;
		GPIO_0    = '0;
		GPIO_1    = '0;
		adc_in    = '0;
		exp_words = '0;
		exp_led   = '0;
		exp_dac   = '0;
		chk_cfg   = 1'b0;
		chk_dac   = 1'b0;
		next_cycle(4);
		rst_n = 1'b1;
		check_state(4);
		load_session(17, 16'($urandom_range(0, 16'h3000)), 14'($urandom), 1'b0);
		send_tick($urandom); // Ignored after done
		send_tick($urandom);
		run_samples(NUM_SAMPLES);
		set_session(1'b0);
		check_state(4);
		load_session($urandom_range(3, 10), 16'($urandom), 14'($urandom), 1'b0);
		set_session(1'b0); // Dropped mid-session
		check_state(4);
		// Gain near -8 drives large samples into saturation
		load_session(17, 16'h8000 | 16'($urandom_range(0, 16'h1000)), 14'($urandom), 1'b1);
		run_samples(NUM_SAMPLES);
		set_session(1'b0);
		k = $urandom_range(0, 14);
		load_session(k + 1, 16'($urandom), 14'($urandom), 1'b0);
		check_state(8);
		errors = mon_errors + UUT.u_checker.fail_count;
		$display("Checks: %0d, errors: %0d", mon_checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge ADC_CLK);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/config_pkg.sv
rtl/gpio_sync.sv
rtl/configer.sv
rtl/param_bank.sv
rtl/adc_scaler.sv
rtl/config_top.sv
dv/config_checker.sv
dv/config_monitor.sv
dv/config_tb.sv

// File: rtl/adc_scaler.sv
/*
 * ADC to DAC sample scaler
 * Gain, offset, invert and saturation in a two-stage pipeline
 */
`timescale 1ns/1ps
`default_nettype none

`include "config_cfg.svh"

module adc_scaler (
	input  logic                    ADC_CLK,
	input  logic                    rst_n,
	input  logic                    cfg_done,
	input  config_pkg::param_bank_t params,
	input  config_pkg::adc_sample_t adc_in,
	output config_pkg::dac_code_t   dac_out
);

	localparam int GAIN_W = 16;
	localparam int PROD_W = `ADC_WIDTH + GAIN_W;
	localparam int SUM_W  = PROD_W + 1;
	localparam logic signed [SUM_W-1:0] DAC_MAX = (1 <<< (`DAC_WIDTH - 1)) - 1;
	localparam logic signed [SUM_W-1:0] DAC_MIN = -(1 <<< (`DAC_WIDTH - 1));

	logic signed [GAIN_W-1:0]     gain;
	logic signed [`DAC_WIDTH-1:0] offset;
	logic                         invert;
	logic signed [PROD_W-1:0]     prod_q;
	logic signed [PROD_W-1:0]     shifted;
	logic signed [SUM_W-1:0]      sum;
	logic signed [SUM_W-1:0]      signed_sum;
	config_pkg::dac_code_t        sat;

	assign gain   = params.word_0[GAIN_W-1:0];
	assign offset = params.word_1[`DAC_WIDTH-1:0];
	assign invert = params.word_2[0];

	// Stage 1
	always_ff @(posedge ADC_CLK)
	begin
		prod_q <= adc_in * gain;
	end

	always_comb
	begin
		shifted    = prod_q >>> `SCALE_SHIFT;
		sum        = shifted + offset;
		signed_sum = invert ? -sum : sum;
		if (signed_sum > DAC_MAX)
			sat = {1'b0, {(`DAC_WIDTH - 1){1'b1}}};
		else if (signed_sum < DAC_MIN)
			sat = {1'b1, {(`DAC_WIDTH - 1){1'b0}}};
		else
			sat = signed_sum[`DAC_WIDTH-1:0];
	end

	// Stage 2, output held at zero until the bank is complete
	always_ff @(posedge ADC_CLK)
	begin
		if (!rst_n || !cfg_done)
			dac_out <= '0;
		else
			dac_out <= sat;
	end

endmodule

`default_nettype wire

// File: rtl/config_cfg.svh
/*
 * Board configuration constants for the ADC/DAC front end
 * Converter widths, GPIO width, parameter count and gain format
 */
`ifndef CONFIG_CFG_SVH
`define CONFIG_CFG_SVH

// Host interface
`define GPIO_WIDTH 32
`define LED_WIDTH 8
`define NUM_PARAMS 16

// Converters
`define ADC_WIDTH 12
`define DAC_WIDTH 14

`define SCALE_SHIFT 12 // Gain is Q4.12

`endif

// File: rtl/config_pkg.sv
/*
 * Shared types for the configuration loader and sample scaler
 */
`default_nettype none

`include "config_cfg.svh"

package config_pkg;

	typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;
	typedef logic [$clog2(`NUM_PARAMS)-1:0] param_idx_t;
	typedef logic signed [`ADC_WIDTH-1:0] adc_sample_t;
	typedef logic signed [`DAC_WIDTH-1:0] dac_code_t;
	typedef logic [`LED_WIDTH-1:0] led_word_t;

	// word_0 sits in the low 32 bits, so word_k matches index k of a packed array
	typedef struct packed {
		gpio_word_t word_15;
		gpio_word_t word_14;
		gpio_word_t word_13;
		gpio_word_t word_12;
		gpio_word_t word_11;
		gpio_word_t word_10;
		gpio_word_t word_9;
		gpio_word_t word_8;
		gpio_word_t word_7;
		gpio_word_t word_6;
		gpio_word_t word_5;
		gpio_word_t word_4;
		gpio_word_t word_3;
		gpio_word_t word_2;
		gpio_word_t word_1;
		gpio_word_t word_0;
	} param_bank_t;

	typedef enum logic [4:0] {
		stopped = 5'd0,
		load_0 = 5'd1, load_1 = 5'd2, load_2 = 5'd3, load_3 = 5'd4,
		load_4 = 5'd5, load_5 = 5'd6, load_6 = 5'd7, load_7 = 5'd8,
		load_8 = 5'd9, load_9 = 5'd10, load_10 = 5'd11, load_11 = 5'd12,
		load_12 = 5'd13, load_13 = 5'd14, load_14 = 5'd15, load_15 = 5'd16,
		done = 5'd17
	} load_state_t;

endpackage

`default_nettype wire

// File: rtl/config_top.sv
/*
 * Configuration front end top level
 * GPIO synchronizer, loader FSM, parameter bank and sample scaler
 */
`timescale 1ns/1ps
`default_nettype none

`include "config_cfg.svh"

module config_top (
	input  logic                    ADC_CLK,
	input  logic                    rst_n,
	input  config_pkg::gpio_word_t  GPIO_0,
	input  config_pkg::gpio_word_t  GPIO_1,
	input  config_pkg::adc_sample_t adc_in,
	output config_pkg::led_word_t   led_out,
	output config_pkg::param_bank_t params,
	output logic                    cfg_done,
	output config_pkg::dac_code_t   dac_out
);

	logic                   session_en;
	logic                   tick;
	logic                   wr_en;
	config_pkg::param_idx_t wr_idx;
	logic                   clear;

	gpio_sync u_gpio_sync (
		.ADC_CLK    (ADC_CLK),
		.rst_n      (rst_n),
		.gpio_ctl   (GPIO_0[`GPIO_WIDTH-1:`GPIO_WIDTH-2]), // Enable and tick bits
		.session_en (session_en),
		.tick       (tick)
	);

	configer u_configer (
		.ADC_CLK    (ADC_CLK),
		.rst_n      (rst_n),
		.session_en (session_en),
		.tick       (tick),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.clear      (clear),
		.cfg_done   (cfg_done),
		.led_out    (led_out)
	);

	param_bank u_param_bank (
		.ADC_CLK (ADC_CLK),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.clear   (clear),
		.wr_data (GPIO_1),
		.params  (params)
	);

	adc_scaler u_adc_scaler (
		.ADC_CLK  (ADC_CLK),
		.rst_n    (rst_n),
		.cfg_done (cfg_done),
		.params   (params),
		.adc_in   (adc_in),
		.dac_out  (dac_out)
	);

endmodule

`default_nettype wire

// File: rtl/configer.sv
/*
 * Parameter loader FSM
 * Steps through the 16 word loads on each tick and shows its state on the LEDs
 */
`timescale 1ns/1ps
`default_nettype none

module configer (
	input  logic                   ADC_CLK,
	input  logic                   rst_n,
	input  logic                   session_en,
	input  logic                   tick,
	output logic                   wr_en,
	output config_pkg::param_idx_t wr_idx,
	output logic                   clear,
	output logic                   cfg_done,
	output config_pkg::led_word_t  led_out
);

	config_pkg::load_state_t state;
	config_pkg::load_state_t next_state;
	logic                    wr_next;

	always_comb
	begin
		next_state = state;
		wr_next    = 1'b0;
		if (tick)
		begin
			case (state)
				config_pkg::done:
					next_state = config_pkg::done; // Extra ticks ignored
				config_pkg::load_15:
					next_state = config_pkg::done; // Last tick closes the session
				default:
				begin
					// stopped and load_0..load_14 each load one word
					next_state = config_pkg::load_state_t'(state + 5'd1);
					wr_next    = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge ADC_CLK)
	begin
		if (!rst_n)
		begin
			state  <= config_pkg::stopped;
			wr_en  <= 1'b0;
			wr_idx <= '0;
			clear  <= 1'b0;
		end
		else
		begin
			clear <= ~session_en;
			if (!session_en)
			begin
				state <= config_pkg::stopped;
				wr_en <= 1'b0;
			end
			else
			begin
				state <= next_state;
				wr_en <= wr_next;
			end
			// State code k+1 means word k is loaded, so low bits give the next index
			wr_idx <= state[3:0];
		end
	end

	assign cfg_done = (state == config_pkg::done);
	assign led_out  = config_pkg::led_word_t'(state);

endmodule

`default_nettype wire

// File: rtl/gpio_sync.sv
/*
 * GPIO control synchronizer
 * Brings the session enable and tick bits into ADC_CLK, tick becomes a pulse
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_sync (
	input  logic       ADC_CLK,
	input  logic       rst_n,
	input  logic [1:0] gpio_ctl, // [1] session enable, [0] tick strobe
	output logic       session_en,
	output logic       tick
);

	logic [1:0] en_sync;
	logic [1:0] tick_sync;
	logic       tick_dly;

	always_ff @(posedge ADC_CLK)
	begin
		if (!rst_n)
		begin
			en_sync   <= 2'b00;
			tick_sync <= 2'b00;
			tick_dly  <= 1'b0;
			tick      <= 1'b0;
		end
		else
		begin
			en_sync   <= {en_sync[0], gpio_ctl[1]};
			tick_sync <= {tick_sync[0], gpio_ctl[0]};
			tick_dly  <= tick_sync[1];
			// Rising edge only, and never outside a session
			tick      <= tick_sync[1] & ~tick_dly & en_sync[1];
		end
	end

	assign session_en = en_sync[1];

endmodule

`default_nettype wire

// File: rtl/param_bank.sv
/*
 * Parameter register file
 * Sixteen 32-bit words, written one at a time, cleared together
 */
`timescale 1ns/1ps
`default_nettype none

`include "config_cfg.svh"

module param_bank (
	input  logic                    ADC_CLK,
	input  logic                    rst_n,
	input  logic                    wr_en,
	input  config_pkg::param_idx_t  wr_idx,
	input  logic                    clear,
	input  config_pkg::gpio_word_t  wr_data,
	output config_pkg::param_bank_t params
);

	config_pkg::gpio_word_t [`NUM_PARAMS-1:0] words;

	always_ff @(posedge ADC_CLK)
	begin
		if (!rst_n || clear)
		begin
			words <= '0;
		end
		else if (wr_en)
		begin
			words[wr_idx] <= wr_data;
		end
	end

	// Same layout as the struct, word_0 in the low bits
	assign params = words;

endmodule

`default_nettype wire
